/* verilog/dispatch_pkg.sv */
/* Shared widths, slot count and decoded-field encodings for the dispatch stage.
   Imported by every dispatch module and by the testbench. */
package dispatch_pkg;

    // datapath width of the RV32 core
    localparam int XLEN = 32;

    // register file index width
    localparam int REG_ADDR_W = 5;

    // long instructions that may be in flight at once
    localparam int LONG_SLOTS = 4;
    localparam int COMMIT_ID_W = $clog2(LONG_SLOTS);

    // opaque operation code, passed through to the ALU or muldiv unit
    localparam int OP_W = 4;

    // one strobe per byte of a word
    localparam int WMASK_W = XLEN / 8;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [COMMIT_ID_W-1:0] commit_id_t;
    typedef logic [OP_W-1:0] op_t;
    typedef logic [WMASK_W-1:0] wmask_t;

    // functional unit that takes the instruction
    typedef enum logic [1:0] {
        UNIT_ALU    = 2'd0,
        UNIT_MEM    = 2'd1,
        UNIT_MULDIV = 2'd2
    } unit_e;

    // load/store access size
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } mem_size_e;

endpackage

/* verilog/dispatch_logic.sv */
/* Combinational part of dispatch: unit requests, ALU operands and the
   load/store address, byte mask, shifted store data and misalignment flags. */
module dispatch_logic
    import dispatch_pkg::*;
(
    input  logic      inst_valid_i,
    input  unit_e     dec_unit_i,
    input  logic      dec_use_pc_i,
    input  logic      dec_use_imm_i,
    input  logic      dec_mem_store_i,
    input  mem_size_e dec_mem_size_i,
    input  xlen_t     dec_imm_i,
    input  xlen_t     dec_pc_i,
    input  xlen_t     rs1_rdata_i,
    input  xlen_t     rs2_rdata_i,

    output logic      req_alu_o,
    output logic      req_mem_o,
    output logic      req_muldiv_o,
    output xlen_t     alu_op1_o,
    output xlen_t     alu_op2_o,
    output xlen_t     mem_addr_o,
    output wmask_t    mem_wmask_o,
    output xlen_t     mem_wdata_o,
    output logic      misaligned_load_o,
    output logic      misaligned_store_o,
    output logic      long_o
);

    logic       is_mem;
    logic       misaligned;
    logic [1:0] byte_off;
    wmask_t     size_mask;

    assign req_alu_o    = inst_valid_i && (dec_unit_i == UNIT_ALU);
    assign req_muldiv_o = inst_valid_i && (dec_unit_i == UNIT_MULDIV);
    assign is_mem       = inst_valid_i && (dec_unit_i == UNIT_MEM);

    // operand muxes
    assign alu_op1_o = dec_use_pc_i ? dec_pc_i : rs1_rdata_i;
    assign alu_op2_o = dec_use_imm_i ? dec_imm_i : rs2_rdata_i;

    // effective address, rs1 + imm
    assign mem_addr_o = rs1_rdata_i + dec_imm_i;
    assign byte_off   = mem_addr_o[1:0];

    always_comb begin
        case (dec_mem_size_i)
            SIZE_HALF: misaligned = byte_off[0];
            SIZE_WORD: misaligned = (byte_off != 2'b00);
            default:   misaligned = 1'b0;
        endcase
    end

    // a misaligned access is reported as an exception, not sent to memory
    assign req_mem_o          = is_mem && !misaligned;
    assign misaligned_load_o  = is_mem && misaligned && !dec_mem_store_i;
    assign misaligned_store_o = is_mem && misaligned && dec_mem_store_i;

    always_comb begin
        case (dec_mem_size_i)
            SIZE_BYTE: size_mask = 4'b0001;
            SIZE_HALF: size_mask = 4'b0011;
            SIZE_WORD: size_mask = 4'b1111;
            default:   size_mask = 4'b0000;
        endcase
    end

    // strobes only for stores that actually go out
    assign mem_wmask_o = (req_mem_o && dec_mem_store_i) ? wmask_t'(size_mask << byte_off) : '0;

    // store data lined up with its byte lanes
    assign mem_wdata_o = rs2_rdata_i << {byte_off, 3'b000};

    // loads and muldiv write back late and need a commit id
    assign long_o = (req_mem_o && !dec_mem_store_i) || req_muldiv_o;

    // an access sent to memory never spills past the top byte lane
    always_comb begin
        if (req_mem_o) begin
            assert ((8'(size_mask) << byte_off) <= 8'h0f)
                else $error("memory request crosses a word boundary");
        end
    end

endmodule

/* verilog/hazard_unit.sv */
/* Tracks long instructions still in flight, hands out commit ids and raises
   a stall on register conflicts with them or when every slot is taken. */
module hazard_unit
    import dispatch_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic       inst_valid_i,
    input  logic       long_i,
    input  logic       issue_i,
    input  reg_addr_t  rd_addr_i,
    input  reg_addr_t  rs1_addr_i,
    input  reg_addr_t  rs2_addr_i,
    input  logic       reg_we_i,
    input  logic       commit_valid_i,
    input  commit_id_t commit_id_i,

    output logic       hazard_o,
    output commit_id_t alloc_id_o
);

    logic [LONG_SLOTS-1:0] busy_q;
    reg_addr_t             rd_q [LONG_SLOTS];

    logic conflict;
    logic full;

    // compare against the table before this edge's updates
    always_comb begin
        conflict = 1'b0;
        for (int i = 0; i < LONG_SLOTS; i++) begin
            if (busy_q[i] && (rd_q[i] != '0)) begin
                if ((rd_q[i] == rs1_addr_i) || (rd_q[i] == rs2_addr_i)) begin
                    conflict = 1'b1;
                end
                if (reg_we_i && (rd_q[i] == rd_addr_i)) begin
                    conflict = 1'b1;
                end
            end
        end
    end

    assign full     = &busy_q;
    assign hazard_o = inst_valid_i && (conflict || (long_i && full));

    // lowest free slot wins
    always_comb begin
        alloc_id_o = '0;
        for (int i = LONG_SLOTS - 1; i >= 0; i--) begin
            if (!busy_q[i]) begin
                alloc_id_o = commit_id_t'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q <= '0;
        end else begin
            if (commit_valid_i) begin
                busy_q[commit_id_i] <= 1'b0;
            end
            // alloc_id_o only points at a slot that was free before this edge
            if (issue_i && long_i) begin
                busy_q[alloc_id_o] <= 1'b1;
            end
        end
    end

    // destination register of each claimed slot
    always_ff @(posedge clk) begin
        if (issue_i && long_i) begin
            rd_q[alloc_id_o] <= rd_addr_i;
        end
    end

    // writeback must only retire an instruction that is in flight
    assert property (@(posedge clk) disable iff (!rst_n_i)
        commit_valid_i |-> busy_q[commit_id_i])
        else $error("commit of a free slot %0d", commit_id_i);

    // the issue register must honour the stall raised here
    assert property (@(posedge clk) disable iff (!rst_n_i)
        issue_i |-> !hazard_o)
        else $error("instruction issued under a hazard stall");

endmodule

/* verilog/dispatch_pipe.sv */
/* Issue register between dispatch and the functional units. Holds under an
   external stall and drops in a bubble when nothing is accepted. */
module dispatch_pipe
    import dispatch_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic       stall_i,
    input  logic       inst_valid_i,
    input  logic       hazard_i,
    input  commit_id_t alloc_id_i,
    input  op_t        dec_op_i,
    input  xlen_t      dec_pc_i,
    input  reg_addr_t  rd_addr_i,
    input  logic       reg_we_i,
    input  mem_size_e  dec_mem_size_i,
    input  logic       dec_mem_unsigned_i,
    input  logic       dec_mem_store_i,
    input  xlen_t      rs1_rdata_i,
    input  xlen_t      rs2_rdata_i,
    input  logic       req_alu_i,
    input  logic       req_mem_i,
    input  logic       req_muldiv_i,
    input  xlen_t      alu_op1_i,
    input  xlen_t      alu_op2_i,
    input  xlen_t      mem_addr_i,
    input  wmask_t     mem_wmask_i,
    input  xlen_t      mem_wdata_i,
    input  logic       misaligned_load_i,
    input  logic       misaligned_store_i,

    output logic       issue_o,
    output logic       pipe_valid_o,
    output xlen_t      pipe_pc_o,
    output logic       pipe_reg_we_o,
    output reg_addr_t  pipe_rd_addr_o,
    output commit_id_t commit_id_o,
    output logic       req_alu_o,
    output op_t        alu_op_o,
    output xlen_t      alu_op1_o,
    output xlen_t      alu_op2_o,
    output logic       req_mem_o,
    output logic       mem_load_o,
    output logic       mem_store_o,
    output mem_size_e  mem_size_o,
    output logic       mem_unsigned_o,
    output xlen_t      mem_addr_o,
    output wmask_t     mem_wmask_o,
    output xlen_t      mem_wdata_o,
    output logic       misaligned_load_o,
    output logic       misaligned_store_o,
    output logic       req_muldiv_o,
    output op_t        muldiv_op_o,
    output xlen_t      muldiv_op1_o,
    output xlen_t      muldiv_op2_o
);

    op_t   op_q;
    xlen_t rs1_q;
    xlen_t rs2_q;

    assign issue_o = inst_valid_i && !stall_i && !hazard_i;

    // valid, requests and exception flags; a bubble clears them
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pipe_valid_o       <= 1'b0;
            req_alu_o          <= 1'b0;
            req_mem_o          <= 1'b0;
            req_muldiv_o       <= 1'b0;
            misaligned_load_o  <= 1'b0;
            misaligned_store_o <= 1'b0;
        end else if (!stall_i) begin
            pipe_valid_o       <= issue_o;
            req_alu_o          <= issue_o && req_alu_i;
            req_mem_o          <= issue_o && req_mem_i;
            req_muldiv_o       <= issue_o && req_muldiv_i;
            misaligned_load_o  <= issue_o && misaligned_load_i;
            misaligned_store_o <= issue_o && misaligned_store_i;
        end
    end

    // payload loads only on an accepted instruction, so it also holds on stall
    always_ff @(posedge clk) begin
        if (issue_o) begin
            pipe_pc_o      <= dec_pc_i;
            pipe_reg_we_o  <= reg_we_i;
            pipe_rd_addr_o <= rd_addr_i;
            commit_id_o    <= alloc_id_i;
            op_q           <= dec_op_i;
            alu_op1_o      <= alu_op1_i;
            alu_op2_o      <= alu_op2_i;
            mem_load_o     <= req_mem_i && !dec_mem_store_i;
            mem_store_o    <= req_mem_i && dec_mem_store_i;
            mem_size_o     <= dec_mem_size_i;
            mem_unsigned_o <= dec_mem_unsigned_i;
            mem_addr_o     <= mem_addr_i;
            mem_wmask_o    <= mem_wmask_i;
            mem_wdata_o    <= mem_wdata_i;
            rs1_q          <= rs1_rdata_i;
            rs2_q          <= rs2_rdata_i;
        end
    end

    // ALU and muldiv share the decoded op
    assign alu_op_o     = op_q;
    assign muldiv_op_o  = op_q;
    assign muldiv_op1_o = rs1_q;
    assign muldiv_op2_o = rs2_q;

    // decode picks a single unit, so at most one request or exception flag is up
    assert property (@(posedge clk) disable iff (!rst_n_i)
        $onehot0({req_alu_o, req_mem_o, req_muldiv_o,
                  misaligned_load_o, misaligned_store_o}))
        else $error("more than one unit request in the issue register");

endmodule

/* verilog/dispatch.sv */
/* Dispatch stage of the RV32 core: operand selection, long-instruction
   hazard tracking and the issue register toward the functional units. */
module dispatch
    import dispatch_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic       stall_i,

    // decoded instruction
    input  logic       inst_valid_i,
    input  unit_e      dec_unit_i,
    input  op_t        dec_op_i,
    input  logic       dec_use_pc_i,
    input  logic       dec_use_imm_i,
    input  logic       dec_mem_store_i,
    input  mem_size_e  dec_mem_size_i,
    input  logic       dec_mem_unsigned_i,
    input  xlen_t      dec_imm_i,
    input  xlen_t      dec_pc_i,
    input  xlen_t      rs1_rdata_i,
    input  xlen_t      rs2_rdata_i,
    input  reg_addr_t  rd_addr_i,
    input  reg_addr_t  rs1_addr_i,
    input  reg_addr_t  rs2_addr_i,
    input  logic       reg_we_i,

    // writeback commit
    input  logic       commit_valid_i,
    input  commit_id_t commit_id_i,

    output logic       hazard_stall_o,
    output logic       pipe_valid_o,
    output xlen_t      pipe_pc_o,
    output logic       pipe_reg_we_o,
    output reg_addr_t  pipe_rd_addr_o,
    output commit_id_t commit_id_o,

    // ALU
    output logic       req_alu_o,
    output op_t        alu_op_o,
    output xlen_t      alu_op1_o,
    output xlen_t      alu_op2_o,

    // load/store unit
    output logic       req_mem_o,
    output logic       mem_load_o,
    output logic       mem_store_o,
    output mem_size_e  mem_size_o,
    output logic       mem_unsigned_o,
    output xlen_t      mem_addr_o,
    output wmask_t     mem_wmask_o,
    output xlen_t      mem_wdata_o,
    output logic       misaligned_load_o,
    output logic       misaligned_store_o,

    // muldiv
    output logic       req_muldiv_o,
    output op_t        muldiv_op_o,
    output xlen_t      muldiv_op1_o,
    output xlen_t      muldiv_op2_o
);

    logic       issue;
    logic       long_inst;
    commit_id_t alloc_id;

    logic   logic_req_alu;
    logic   logic_req_mem;
    logic   logic_req_muldiv;
    xlen_t  logic_alu_op1;
    xlen_t  logic_alu_op2;
    xlen_t  logic_mem_addr;
    wmask_t logic_mem_wmask;
    xlen_t  logic_mem_wdata;
    logic   logic_misaligned_load;
    logic   logic_misaligned_store;

    dispatch_logic u_dispatch_logic (
        .inst_valid_i      (inst_valid_i),
        .dec_unit_i        (dec_unit_i),
        .dec_use_pc_i      (dec_use_pc_i),
        .dec_use_imm_i     (dec_use_imm_i),
        .dec_mem_store_i   (dec_mem_store_i),
        .dec_mem_size_i    (dec_mem_size_i),
        .dec_imm_i         (dec_imm_i),
        .dec_pc_i          (dec_pc_i),
        .rs1_rdata_i       (rs1_rdata_i),
        .rs2_rdata_i       (rs2_rdata_i),
        .req_alu_o         (logic_req_alu),
        .req_mem_o         (logic_req_mem),
        .req_muldiv_o      (logic_req_muldiv),
        .alu_op1_o         (logic_alu_op1),
        .alu_op2_o         (logic_alu_op2),
        .mem_addr_o        (logic_mem_addr),
        .mem_wmask_o       (logic_mem_wmask),
        .mem_wdata_o       (logic_mem_wdata),
        .misaligned_load_o (logic_misaligned_load),
        .misaligned_store_o(logic_misaligned_store),
        .long_o            (long_inst)
    );

    hazard_unit u_hazard_unit (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .inst_valid_i  (inst_valid_i),
        .long_i        (long_inst),
        .issue_i       (issue),
        .rd_addr_i     (rd_addr_i),
        .rs1_addr_i    (rs1_addr_i),
        .rs2_addr_i    (rs2_addr_i),
        .reg_we_i      (reg_we_i),
        .commit_valid_i(commit_valid_i),
        .commit_id_i   (commit_id_i),
        .hazard_o      (hazard_stall_o),
        .alloc_id_o    (alloc_id)
    );

    dispatch_pipe u_dispatch_pipe (
        .clk               (clk),
        .rst_n_i           (rst_n_i),
        .stall_i           (stall_i),
        .inst_valid_i      (inst_valid_i),
        .hazard_i          (hazard_stall_o),
        .alloc_id_i        (alloc_id),
        .dec_op_i          (dec_op_i),
        .dec_pc_i          (dec_pc_i),
        .rd_addr_i         (rd_addr_i),
        .reg_we_i          (reg_we_i),
        .dec_mem_size_i    (dec_mem_size_i),
        .dec_mem_unsigned_i(dec_mem_unsigned_i),
        .dec_mem_store_i   (dec_mem_store_i),
        .rs1_rdata_i       (rs1_rdata_i),
        .rs2_rdata_i       (rs2_rdata_i),
        .req_alu_i         (logic_req_alu),
        .req_mem_i         (logic_req_mem),
        .req_muldiv_i      (logic_req_muldiv),
        .alu_op1_i         (logic_alu_op1),
        .alu_op2_i         (logic_alu_op2),
        .mem_addr_i        (logic_mem_addr),
        .mem_wmask_i       (logic_mem_wmask),
        .mem_wdata_i       (logic_mem_wdata),
        .misaligned_load_i (logic_misaligned_load),
        .misaligned_store_i(logic_misaligned_store),
        .issue_o           (issue),
        .pipe_valid_o      (pipe_valid_o),
        .pipe_pc_o         (pipe_pc_o),
        .pipe_reg_we_o     (pipe_reg_we_o),
        .pipe_rd_addr_o    (pipe_rd_addr_o),
        .commit_id_o       (commit_id_o),
        .req_alu_o         (req_alu_o),
        .alu_op_o          (alu_op_o),
        .alu_op1_o         (alu_op1_o),
        .alu_op2_o         (alu_op2_o),
        .req_mem_o         (req_mem_o),
        .mem_load_o        (mem_load_o),
        .mem_store_o       (mem_store_o),
        .mem_size_o        (mem_size_o),
        .mem_unsigned_o    (mem_unsigned_o),
        .mem_addr_o        (mem_addr_o),
        .mem_wmask_o       (mem_wmask_o),
        .mem_wdata_o       (mem_wdata_o),
        .misaligned_load_o (misaligned_load_o),
        .misaligned_store_o(misaligned_store_o),
        .req_muldiv_o      (req_muldiv_o),
        .muldiv_op_o       (muldiv_op_o),
        .muldiv_op1_o      (muldiv_op1_o),
        .muldiv_op2_o      (muldiv_op2_o)
    );

endmodule

/* tests/dispatch_model.svh */
/* Reference model of the dispatch stage, included inside the testbench module.
   Mirrors the slot table and predicts the stall and the issue register. */
`ifndef DISPATCH_MODEL_SVH
`define DISPATCH_MODEL_SVH

logic      m_busy [LONG_SLOTS];
reg_addr_t m_rd   [LONG_SLOTS];

// expected issue register after the last edge
logic       e_valid, e_alu, e_mem, e_muldiv, e_mis_load, e_mis_store;
logic       e_long, e_load, e_store, e_reg_we, e_unsigned;
xlen_t      e_pc, e_op1, e_op2, e_addr, e_wdata, e_rs1, e_rs2;
reg_addr_t  e_rd;
commit_id_t e_cid;
op_t        e_op;
mem_size_e  e_size;
wmask_t     e_wmask;

// upstream keeps an instruction that was not accepted
logic hold;

task automatic model_reset();
    for (int i = 0; i < LONG_SLOTS; i++) begin
        m_busy[i] = 1'b0;
    end
    e_valid     = 1'b0;
    e_alu       = 1'b0;
    e_mem       = 1'b0;
    e_muldiv    = 1'b0;
    e_mis_load  = 1'b0;
    e_mis_store = 1'b0;
    e_long      = 1'b0;
    hold        = 1'b0;
endtask

// half needs an even address, word a multiple of four
function automatic logic model_misaligned(mem_size_e size, logic [1:0] off);
    return ((size == SIZE_HALF) && off[0]) || ((size == SIZE_WORD) && (off != 2'b00));
endfunction

// one strobe per accessed byte, starting at the address offset
function automatic wmask_t model_wmask(mem_size_e size, logic [1:0] off);
    int     nbytes;
    int     o;
    wmask_t m;
    nbytes = (size == SIZE_BYTE) ? 1 : ((size == SIZE_HALF) ? 2 : 4);
    o = int'(off);
    m = '0;
    for (int b = 0; b < 4; b++) begin
        if ((b >= o) && (b < o + nbytes)) begin
            m[b] = 1'b1;
        end
    end
    return m;
endfunction

// one clock cycle: predicted stall now, issue register and table after the edge
task automatic model_cycle(output logic hazard);
    xlen_t      addr;
    logic [1:0] off;
    logic       is_mem, mis, mem_ok, is_muldiv, is_long;
    logic       conflict, full, issue;
    commit_id_t alloc;
    addr      = rs1_rdata_i + dec_imm_i;
    off       = addr[1:0];
    is_mem    = inst_valid_i && (dec_unit_i == UNIT_MEM);
    is_muldiv = inst_valid_i && (dec_unit_i == UNIT_MULDIV);
    mis       = is_mem && model_misaligned(dec_mem_size_i, off);
    mem_ok    = is_mem && !mis;
    is_long   = (mem_ok && !dec_mem_store_i) || is_muldiv;

    conflict = 1'b0;
    full     = 1'b1;
    alloc    = '0;
    for (int i = 0; i < LONG_SLOTS; i++) begin
        if (!m_busy[i]) begin
            // first free slot seen is the lowest one
            if (full) begin
                alloc = commit_id_t'(i);
            end
            full = 1'b0;
        end else if (m_rd[i] != 5'd0) begin
            if ((m_rd[i] == rs1_addr_i) || (m_rd[i] == rs2_addr_i) ||
                (reg_we_i && (m_rd[i] == rd_addr_i))) begin
                conflict = 1'b1;
            end
        end
    end
    hazard = inst_valid_i && (conflict || (is_long && full));
    issue  = inst_valid_i && !stall_i && !hazard;

    if (!stall_i) begin
        e_valid     = issue;
        e_alu       = issue && (dec_unit_i == UNIT_ALU);
        e_mem       = issue && mem_ok;
        e_muldiv    = issue && is_muldiv;
        e_mis_load  = issue && mis && !dec_mem_store_i;
        e_mis_store = issue && mis && dec_mem_store_i;
    end
    if (issue) begin
        e_long     = is_long;
        e_pc       = dec_pc_i;
        e_reg_we   = reg_we_i;
        e_rd       = rd_addr_i;
        e_cid      = alloc;
        e_op       = dec_op_i;
        e_op1      = dec_use_pc_i ? dec_pc_i : rs1_rdata_i;
        e_op2      = dec_use_imm_i ? dec_imm_i : rs2_rdata_i;
        e_load     = mem_ok && !dec_mem_store_i;
        e_store    = mem_ok && dec_mem_store_i;
        e_size     = dec_mem_size_i;
        e_unsigned = dec_mem_unsigned_i;
        e_addr     = addr;
        e_wmask    = (mem_ok && dec_mem_store_i) ? model_wmask(dec_mem_size_i, off) : '0;
        e_wdata    = rs2_rdata_i << (8 * off);
        e_rs1      = rs1_rdata_i;
        e_rs2      = rs2_rdata_i;
    end

    // slot table at the coming edge
    if (commit_valid_i) begin
        m_busy[commit_id_i] = 1'b0;
    end
    if (issue && is_long) begin
        m_busy[alloc] = 1'b1;
        m_rd[alloc]   = rd_addr_i;
    end
    hold = inst_valid_i && !issue;
endtask

`endif

/* tests/tb_dispatch.sv */
/* Random-stimulus testbench for the dispatch stage. Drives the top level on the
   falling edge and checks every cycle against the included reference model. */
module tb_dispatch
    import dispatch_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int T_ALU      = 0;
    localparam int T_STORE    = 1;
    localparam int T_MISALIGN = 2;
    localparam int T_LONG     = 3;
    localparam int T_STALL    = 4;

    localparam int N_ALU      = 200;
    localparam int N_STORE    = 300;
    localparam int N_MISALIGN = 200;
    localparam int N_LONG     = 500;
    localparam int N_STALL    = 500;
    localparam int TOTAL_CYCLES = 6 + N_ALU + N_STORE + N_MISALIGN + N_LONG + N_STALL;

    logic       clk, rst_n_i, stall_i, inst_valid_i;
    unit_e      dec_unit_i;
    op_t        dec_op_i;
    logic       dec_use_pc_i, dec_use_imm_i, dec_mem_store_i, dec_mem_unsigned_i;
    mem_size_e  dec_mem_size_i;
    xlen_t      dec_imm_i, dec_pc_i, rs1_rdata_i, rs2_rdata_i;
    reg_addr_t  rd_addr_i, rs1_addr_i, rs2_addr_i;
    logic       reg_we_i, commit_valid_i;
    commit_id_t commit_id_i;

    logic       hazard_stall_o, pipe_valid_o, pipe_reg_we_o;
    xlen_t      pipe_pc_o;
    reg_addr_t  pipe_rd_addr_o;
    commit_id_t commit_id_o;
    logic       req_alu_o, req_mem_o, req_muldiv_o, mem_load_o, mem_store_o, mem_unsigned_o;
    logic       misaligned_load_o, misaligned_store_o;
    op_t        alu_op_o, muldiv_op_o;
    xlen_t      alu_op1_o, alu_op2_o, mem_addr_o, mem_wdata_o, muldiv_op1_o, muldiv_op2_o;
    mem_size_e  mem_size_o;
    wmask_t     mem_wmask_o;

    integer seed = 92;
    int     errors = 0;
    int     n_tests = 0;
    int     n_failed = 0;

    `include "dispatch_model.svh"

    dispatch dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #((TOTAL_CYCLES + 50) * 20);
        $display("timeout: run did not finish within %0d cycles", TOTAL_CYCLES + 50);
        $display("Simulation failed");
        $finish;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_outputs();
        check("pipe_valid_o", 32'(pipe_valid_o), 32'(e_valid));
        check("req_alu_o", 32'(req_alu_o), 32'(e_alu));
        check("req_mem_o", 32'(req_mem_o), 32'(e_mem));
        check("req_muldiv_o", 32'(req_muldiv_o), 32'(e_muldiv));
        check("misaligned_load_o", 32'(misaligned_load_o), 32'(e_mis_load));
        check("misaligned_store_o", 32'(misaligned_store_o), 32'(e_mis_store));
        if (e_valid) begin
            check("pipe_pc_o", pipe_pc_o, e_pc);
            check("pipe_reg_we_o", 32'(pipe_reg_we_o), 32'(e_reg_we));
            check("pipe_rd_addr_o", 32'(pipe_rd_addr_o), 32'(e_rd));
            check("mem_load_o", 32'(mem_load_o), 32'(e_load));
            check("mem_store_o", 32'(mem_store_o), 32'(e_store));
            check("mem_wmask_o", 32'(mem_wmask_o), 32'(e_wmask));
            if (e_long) begin
                check("commit_id_o", 32'(commit_id_o), 32'(e_cid));
            end
            if (e_alu) begin
                check("alu_op_o", 32'(alu_op_o), 32'(e_op));
                check("alu_op1_o", alu_op1_o, e_op1);
                check("alu_op2_o", alu_op2_o, e_op2);
            end
            if (e_mem) begin
                check("mem_size_o", 32'(mem_size_o), 32'(e_size));
                check("mem_unsigned_o", 32'(mem_unsigned_o), 32'(e_unsigned));
                check("mem_addr_o", mem_addr_o, e_addr);
                check("mem_wdata_o", mem_wdata_o, e_wdata);
            end
            if (e_muldiv) begin
                check("muldiv_op_o", 32'(muldiv_op_o), 32'(e_op));
                check("muldiv_op1_o", muldiv_op1_o, e_rs1);
                check("muldiv_op2_o", muldiv_op2_o, e_rs2);
            end
        end
    endtask

    // stall is combinational, so it is checked right after the inputs settle
    task automatic predict_and_check();
        logic exp_hazard;
        #1;
        model_cycle(exp_hazard);
        check("hazard_stall_o", 32'(hazard_stall_o), 32'(exp_hazard));
    endtask

    task automatic drive_inputs(input int mode);
        logic [31:0] r;
        logic        want_commit;
        int          idx;
        r = $random(seed);
        if (!hold) begin
            inst_valid_i = (r[2:0] != 3'd0);
            if (mode == T_ALU) begin
                dec_unit_i = UNIT_ALU;
            end else if ((mode == T_STORE) || (mode == T_MISALIGN) || (r[4:3] == 2'd1)) begin
                dec_unit_i = UNIT_MEM;
            end else begin
                dec_unit_i = (r[4:3] == 2'd0) ? UNIT_ALU : UNIT_MULDIV;
            end
            dec_op_i        = r[8:5];
            dec_use_pc_i    = r[9];
            dec_use_imm_i   = r[10];
            // loads only in the long test, so the table fills up
            dec_mem_store_i = (mode == T_STORE) || ((mode != T_LONG) && r[11]);
            if (mode == T_MISALIGN) begin
                dec_mem_size_i = r[12] ? SIZE_WORD : SIZE_HALF;
            end else begin
                dec_mem_size_i = (r[13:12] == 2'd0) ? SIZE_BYTE :
                                 ((r[13:12] == 2'd1) ? SIZE_HALF : SIZE_WORD);
            end
            dec_mem_unsigned_i = r[14];
            reg_we_i           = r[15];
            // x0..x3 only, so conflicts are frequent
            rd_addr_i   = {3'b000, r[17:16]};
            rs1_addr_i  = {3'b000, r[19:18]};
            rs2_addr_i  = {3'b000, r[21:20]};
            dec_pc_i    = $random(seed);
            dec_imm_i   = $random(seed);
            rs1_rdata_i = $random(seed);
            rs2_rdata_i = $random(seed);
        end
        stall_i = (mode == T_STALL) && (r[23:22] == 2'd0);
        want_commit = (mode == T_LONG) ? (r[26:24] == 3'd0) : r[24];
        commit_valid_i = 1'b0;
        commit_id_i = r[28:27];
        // random busy slot, searched from a random start
        for (int k = 0; k < LONG_SLOTS; k++) begin
            idx = (int'(r[28:27]) + k) % LONG_SLOTS;
            if (want_commit && !commit_valid_i && m_busy[idx]) begin
                commit_valid_i = 1'b1;
                commit_id_i    = commit_id_t'(idx);
            end
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        n_tests++;
        if (errors != errs_before) begin
            n_failed++;
        end
        $display("test %-16s %s (%0d errors)", name,
                 (errors == errs_before) ? "ok" : "FAILED", errors - errs_before);
    endtask

    task automatic reset_test();
        int errs;
        errs = errors;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        check_outputs();
        // first long instruction after reset
        inst_valid_i = 1'b1;
        dec_unit_i   = UNIT_MULDIV;
        reg_we_i     = 1'b1;
        rd_addr_i    = 5'd1;
        predict_and_check();
        @(negedge clk);
        check_outputs();
        check("commit_id_o", 32'(commit_id_o), 32'd0);
        inst_valid_i = 1'b0;
        predict_and_check();
        report_test("reset", errs);
    endtask

    task automatic run_test(input string name, input int mode, input int cycles);
        int errs;
        errs = errors;
        repeat (cycles) begin
            @(negedge clk);
            check_outputs();
            drive_inputs(mode);
            predict_and_check();
        end
        report_test(name, errs);
    endtask

    initial begin
        rst_n_i = 1'b0;
        stall_i = 1'b0;
        inst_valid_i = 1'b0;
        dec_unit_i = UNIT_ALU;
        dec_op_i = '0;
        dec_use_pc_i = 1'b0;
        dec_use_imm_i = 1'b0;
        dec_mem_store_i = 1'b0;
        dec_mem_size_i = SIZE_WORD;
        dec_mem_unsigned_i = 1'b0;
        dec_imm_i = '0;
        dec_pc_i = '0;
        rs1_rdata_i = '0;
        rs2_rdata_i = '0;
        rd_addr_i = '0;
        rs1_addr_i = '0;
        rs2_addr_i = '0;
        reg_we_i = 1'b0;
        commit_valid_i = 1'b0;
        commit_id_i = '0;
        model_reset();

        reset_test();
        run_test("alu_dispatch", T_ALU, N_ALU);
        run_test("store_dispatch", T_STORE, N_STORE);
        run_test("misalignment", T_MISALIGN, N_MISALIGN);
        run_test("long_tracking", T_LONG, N_LONG);
        run_test("stall_bubble", T_STALL, N_STALL);

        // last accepted instruction
        @(negedge clk);
        check_outputs();

        $display("%0d tests run, %0d failed, %0d check errors", n_tests, n_failed, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+tests
verilog/dispatch_pkg.sv
verilog/dispatch_logic.sv
verilog/hazard_unit.sv
verilog/dispatch_pipe.sv
verilog/dispatch.sv
tests/tb_dispatch.sv

/* Makefile */
SOURCES := $(shell grep -v '^+' sim.f) tests/dispatch_model.svh

.PHONY: run clean

run: obj_dir/Vtb_dispatch
	./obj_dir/Vtb_dispatch > sim.log 2>&1 || (cat sim.log; false)
	cat sim.log
	! grep -q "Simulation failed" sim.log

obj_dir/Vtb_dispatch: sim.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_dispatch -f sim.f

clean:
	rm -rf obj_dir sim.log
